/* compile.f */
+incdir+design
design/isa_pkg.sv
design/core_pkg.sv
design/inst_decoder.sv
design/ctrl_regs.sv
design/reg_file.sv
design/exec_unit.sv
design/issue_ctrl.sv
design/rv_exec_top.sv
verification/rv_exec_tb.sv

/* design/core_cfg.svh */
//--------------------------------------------------------------------------
// core configuration defines
// sizes of the register file and datapath, reset value of the group mask
//--------------------------------------------------------------------------

`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// architectural registers, x0 included
`define CORE_NREGS 32
// datapath width
`define CORE_XLEN 32
// bit 0 enables ADD/ADDI, bit 1 enables MUL
`define CORE_OPEN_RESET 2'b11

`endif

/* design/core_pkg.sv */
//--------------------------------------------------------------------------
// core internal traffic
// decoded controls, issue response and configuration requests
//--------------------------------------------------------------------------

`include "core_cfg.svh"

package core_pkg;

  // operand 2 source
  localparam logic OP2_RF  = 1'b0;
  localparam logic OP2_IMM = 1'b1;

  // config register map
  localparam logic [1:0] CFG_ADDR_MASK    = 2'd0;
  localparam logic [1:0] CFG_ADDR_RETIRED = 2'd1;
  localparam logic [1:0] CFG_ADDR_ILLEGAL = 2'd2;

  // one row of the decoder table
  typedef struct packed {
    isa_pkg::rv_uop_t      uop;
    logic [4:0]            raddr0;
    logic [4:0]            raddr1;
    logic [4:0]            waddr;
    logic                  wen;
    isa_pkg::rv_imm_type_t imm_sel;
    logic                  op2_sel;
    logic                  illegal;
  } dec_ctrl_t;

  // returned with ack
  typedef struct packed {
    logic [`CORE_XLEN-1:0] result;
    logic                  wen;
    logic [4:0]            waddr;
    logic                  illegal;
  } issue_rsp_t;

  typedef struct packed {
    logic                  wr;
    logic [1:0]            addr;
    logic [`CORE_XLEN-1:0] wdata;
  } cfg_req_t;

endpackage

/* design/ctrl_regs.sv */
//--------------------------------------------------------------------------
// configuration registers
// opcode-group enable mask plus retired and illegal instruction counters
//--------------------------------------------------------------------------

`timescale 1ns/1ps

`include "core_cfg.svh"

module ctrl_regs (
  input  logic                  clk,
  input  logic                  reset,
  input  core_pkg::cfg_req_t    cfg,
  output logic [`CORE_XLEN-1:0] cfg_rdata,
  input  logic                  retire,
  input  logic                  illegal,
  output isa_pkg::op_group_t    op_enable
);

  import isa_pkg::*;
  import core_pkg::*;

  logic [`CORE_XLEN-1:0] retired_cnt;
  logic [`CORE_XLEN-1:0] illegal_cnt;

  // mask, only address 0 is writable
  always_ff @(posedge clk) begin
    if (reset) begin
      op_enable <= op_group_t'(`CORE_OPEN_RESET);
    end else if (cfg.wr && cfg.addr == CFG_ADDR_MASK) begin
      op_enable <= op_group_t'(cfg.wdata[1:0]);
    end
  end

  // counters wrap
  always_ff @(posedge clk) begin
    if (reset) begin
      retired_cnt <= '0;
      illegal_cnt <= '0;
    end else begin
      if (retire) retired_cnt <= retired_cnt + 1'b1;
      if (illegal) illegal_cnt <= illegal_cnt + 1'b1;
    end
  end

  // read mux, unmapped reads zero
  always_comb begin
    case (cfg.addr)
      CFG_ADDR_MASK:    cfg_rdata = {{(`CORE_XLEN-2){1'b0}}, op_enable};
      CFG_ADDR_RETIRED: cfg_rdata = retired_cnt;
      CFG_ADDR_ILLEGAL: cfg_rdata = illegal_cnt;
      default:          cfg_rdata = '0;
    endcase
  end

  // one completion is either retired or illegal, never both
  assert property (@(posedge clk) disable iff (reset) !(retire && illegal))
    else $error("ctrl_regs: retire and illegal in the same cycle");

endmodule

/* design/exec_unit.sv */
//--------------------------------------------------------------------------
// execution unit
// immediate generation, operand select, ADD/MUL with a registered result
//--------------------------------------------------------------------------

`timescale 1ns/1ps

`include "core_cfg.svh"

module exec_unit (
  input  logic                  clk,
  input  core_pkg::dec_ctrl_t   ctrl,
  input  isa_pkg::rv_inst_t     inst,
  input  logic [`CORE_XLEN-1:0] rdata0,
  input  logic [`CORE_XLEN-1:0] rdata1,
  output logic [`CORE_XLEN-1:0] result
);

  import isa_pkg::*;
  import core_pkg::*;

  logic [`CORE_XLEN-1:0] imm;
  logic [`CORE_XLEN-1:0] op1;
  logic [`CORE_XLEN-1:0] op2;
  logic [`CORE_XLEN-1:0] sum;
  logic [`CORE_XLEN-1:0] prod;

  //------------------------------------------------------------------------
  // operands
  //------------------------------------------------------------------------

  // sign-extended I immediate from the I view of the word
  always_comb begin
    if (ctrl.imm_sel == IMM_I) begin
      imm = {{(`CORE_XLEN-12){inst.i.imm12[11]}}, inst.i.imm12};
    end else begin
      imm = '0;
    end
  end

  assign op1 = rdata0;
  assign op2 = (ctrl.op2_sel == OP2_IMM) ? imm : rdata1;

  //------------------------------------------------------------------------
  // arithmetic
  //------------------------------------------------------------------------

  assign sum  = op1 + op2;
  // low half of the product only
  assign prod = op1 * op2;

  // one cycle, illegal gives zero
  always_ff @(posedge clk) begin
    case (ctrl.uop)
      OP_ADD:  result <= sum;
      OP_MUL:  result <= prod;
      default: result <= '0;
    endcase
  end

endmodule

/* design/inst_decoder.sv */
//--------------------------------------------------------------------------
// instruction decoder
// table lookup from instruction word to micro-op controls, per-group enable
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module inst_decoder (
  input  isa_pkg::rv_inst_t  inst,
  input  isa_pkg::op_group_t op_enable,
  output core_pkg::dec_ctrl_t ctrl
);

  import isa_pkg::*;
  import core_pkg::*;

  localparam logic y = 1'b1;
  localparam logic n = 1'b0;

  // register fields
  logic [4:0]  rs1;
  logic [4:0]  rs2;
  logic [4:0]  rd;
  // funct7, funct3, opcode packed for matching
  logic [16:0] key;

  assign rs1 = inst.r.rs1;
  assign rs2 = inst.r.rs2;
  assign rd  = inst.r.rd;
  assign key = {inst.r.funct7, inst.r.funct3, inst.r.opcode};

  // build one table row
  function automatic dec_ctrl_t row(
    input rv_uop_t      uop,
    input logic [4:0]   raddr0,
    input logic [4:0]   raddr1,
    input logic [4:0]   waddr,
    input logic         wen,
    input rv_imm_type_t imm_sel,
    input logic         op2_sel,
    input logic         illegal
  );
    dec_ctrl_t c;
    c.uop     = uop;
    c.raddr0  = raddr0;
    c.raddr1  = raddr1;
    c.waddr   = waddr;
    c.wen     = wen;
    c.imm_sel = imm_sel;
    c.op2_sel = op2_sel;
    c.illegal = illegal;
    return c;
  endfunction

  //------------------------------------------------------------------------
  // control table
  //------------------------------------------------------------------------

  always_comb begin
    // no match means illegal
    ctrl = row(OP_NONE, 5'd0, 5'd0, 5'd0, n, IMM_NONE, OP2_RF, y);

    // add group
    if (op_enable.add_en) begin
      casez (key) //                     uop     ra0  ra1   wa  wen imm       op2      ill
        {F7_BASE, F3_ADD, OPC_OP}:
          ctrl = row(OP_ADD, rs1, rs2,  rd, y,  IMM_NONE, OP2_RF,  n);
        {7'b???????, F3_ADD, OPC_OP_IMM}:
          ctrl = row(OP_ADD, rs1, 5'd0, rd, y,  IMM_I,    OP2_IMM, n);
        default: ;
      endcase
    end

    // mul group
    if (op_enable.mul_en) begin
      casez (key)
        {F7_MULDIV, F3_ADD, OPC_OP}:
          ctrl = row(OP_MUL, rs1, rs2,  rd, y,  IMM_NONE, OP2_RF,  n);
        default: ;
      endcase
    end
  end

  // a row never both writes and flags illegal
  always_comb begin
    assert (!(ctrl.wen && ctrl.illegal))
      else $error("decoder: wen and illegal both set");
  end

endmodule

/* design/isa_pkg.sv */
//--------------------------------------------------------------------------
// RV32 ISA subset definitions
// opcode and funct encodings, instruction formats, micro-ops
//--------------------------------------------------------------------------

package isa_pkg;

  //------------------------------------------------------------------------
  // encodings
  //------------------------------------------------------------------------

  // major opcodes
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

  // funct7 for base integer ops and the M extension
  localparam logic [6:0] F7_BASE   = 7'b0000000;
  localparam logic [6:0] F7_MULDIV = 7'b0000001;

  // funct3 shared by ADD, ADDI and MUL
  localparam logic [2:0] F3_ADD = 3'b000;

  //------------------------------------------------------------------------
  // instruction formats
  //------------------------------------------------------------------------

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } rv_r_t;

  typedef struct packed {
    logic [11:0] imm12;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } rv_i_t;

  // same 32-bit word, two layouts
  typedef union packed {
    rv_r_t r;
    rv_i_t i;
  } rv_inst_t;

  // linear micro-ops
  typedef enum logic [1:0] {
    OP_NONE = 2'd0,
    OP_ADD  = 2'd1,
    OP_MUL  = 2'd2
  } rv_uop_t;

  typedef enum logic {
    IMM_NONE = 1'b0,
    IMM_I    = 1'b1
  } rv_imm_type_t;

  // per-group enable bits
  typedef struct packed {
    logic mul_en;
    logic add_en;
  } op_group_t;

endpackage

/* design/issue_ctrl.sv */
//--------------------------------------------------------------------------
// issue controller
// four-phase req/ack handshake, steps one instruction through the core
//--------------------------------------------------------------------------

`timescale 1ns/1ps

`include "core_cfg.svh"

module issue_ctrl (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  req,
  input  isa_pkg::rv_inst_t     inst_in,
  input  core_pkg::dec_ctrl_t   ctrl,
  input  logic [`CORE_XLEN-1:0] result,
  output isa_pkg::rv_inst_t     inst,
  output logic                  rf_we,
  output logic                  retire,
  output logic                  illegal,
  output logic                  ack,
  output core_pkg::issue_rsp_t  rsp
);

  typedef enum logic [1:0] {
    IDLE    = 2'd0,
    EXEC    = 2'd1,
    DONE    = 2'd2,
    RELEASE = 2'd3
  } state_t;

  state_t state;

  //------------------------------------------------------------------------
  // FSM
  //------------------------------------------------------------------------

  // IDLE   wait for req, latch word
  // EXEC   decode + read, result registered at the end
  // DONE   write strobe and pulse, ack set at the end
  // RELEASE hold ack until req drops
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
      ack   <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (req && !ack) state <= EXEC;
        end
        EXEC: begin
          state <= DONE;
        end
        DONE: begin
          state <= RELEASE;
          ack   <= 1'b1;
        end
        RELEASE: begin
          // back-pressure while req is held
          if (!req) begin
            state <= IDLE;
            ack   <= 1'b0;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // instruction latch
  always_ff @(posedge clk) begin
    if (state == IDLE && req && !ack) begin
      inst <= inst_in;
    end
  end

  // response captured together with ack
  always_ff @(posedge clk) begin
    if (state == DONE) begin
      rsp.result  <= result;
      rsp.wen     <= ctrl.wen;
      rsp.waddr   <= ctrl.waddr;
      rsp.illegal <= ctrl.illegal;
    end
  end

  // single-cycle strobes in DONE
  assign rf_we   = (state == DONE) && ctrl.wen;
  assign retire  = (state == DONE) && !ctrl.illegal;
  assign illegal = (state == DONE) && ctrl.illegal;

  // ack only answers a live request
  assert property (@(posedge clk) disable iff (reset) $rose(ack) |-> req)
    else $error("issue_ctrl: ack rose without req");

endmodule

/* design/reg_file.sv */
//--------------------------------------------------------------------------
// integer register file
// two combinational read ports, one write port, x0 reads zero
//--------------------------------------------------------------------------

`timescale 1ns/1ps

`include "core_cfg.svh"

module reg_file (
  input  logic                  clk,
  input  logic                  reset,
  input  logic [4:0]            raddr0,
  input  logic [4:0]            raddr1,
  output logic [`CORE_XLEN-1:0] rdata0,
  output logic [`CORE_XLEN-1:0] rdata1,
  input  logic                  we,
  input  logic [4:0]            waddr,
  input  logic [`CORE_XLEN-1:0] wdata
);

  logic [`CORE_XLEN-1:0] regs [`CORE_NREGS];

  // whole array clears on reset
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `CORE_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && waddr != 5'd0) begin
      // x0 writes dropped here
      regs[waddr] <= wdata;
    end
  end

  assign rdata0 = regs[raddr0];
  assign rdata1 = regs[raddr1];

  // x0 stays zero across every write the core issues
  assert property (@(posedge clk) disable iff (reset)
                   (raddr0 == 5'd0) |-> (rdata0 == '0))
    else $error("reg_file: x0 read nonzero on port 0");

  assert property (@(posedge clk) disable iff (reset)
                   (raddr1 == 5'd0) |-> (rdata1 == '0))
    else $error("reg_file: x0 read nonzero on port 1");

endmodule

/* design/rv_exec_top.sv */
//--------------------------------------------------------------------------
// RV32 execution core top level
// issue control, decoder, config block, register file and datapath
//--------------------------------------------------------------------------

`timescale 1ns/1ps

`include "core_cfg.svh"

module rv_exec_top (
  input  logic                  clk,
  input  logic                  reset,
  // issue port
  input  logic                  req,
  input  isa_pkg::rv_inst_t     inst,
  output logic                  ack,
  output core_pkg::issue_rsp_t  rsp,
  // configuration port
  input  core_pkg::cfg_req_t    cfg,
  output logic [`CORE_XLEN-1:0] cfg_rdata
);

  import isa_pkg::*;
  import core_pkg::*;

  rv_inst_t              inst_q;
  dec_ctrl_t             dec_ctrl;
  op_group_t             op_enable;
  logic [`CORE_XLEN-1:0] rdata0;
  logic [`CORE_XLEN-1:0] rdata1;
  logic [`CORE_XLEN-1:0] result;
  logic                  rf_we;
  logic                  retire;
  logic                  illegal;

  issue_ctrl u_issue (
    .clk     (clk),
    .reset   (reset),
    .req     (req),
    .inst_in (inst),
    .ctrl    (dec_ctrl),
    .result  (result),
    .inst    (inst_q),
    .rf_we   (rf_we),
    .retire  (retire),
    .illegal (illegal),
    .ack     (ack),
    .rsp     (rsp)
  );

  // decode from the latched word
  inst_decoder u_dec (
    .inst      (inst_q),
    .op_enable (op_enable),
    .ctrl      (dec_ctrl)
  );

  ctrl_regs u_cfg (
    .clk       (clk),
    .reset     (reset),
    .cfg       (cfg),
    .cfg_rdata (cfg_rdata),
    .retire    (retire),
    .illegal   (illegal),
    .op_enable (op_enable)
  );

  // written from the registered result
  reg_file u_rf (
    .clk    (clk),
    .reset  (reset),
    .raddr0 (dec_ctrl.raddr0),
    .raddr1 (dec_ctrl.raddr1),
    .rdata0 (rdata0),
    .rdata1 (rdata1),
    .we     (rf_we),
    .waddr  (dec_ctrl.waddr),
    .wdata  (result)
  );

  exec_unit u_exec (
    .clk    (clk),
    .ctrl   (dec_ctrl),
    .inst   (inst_q),
    .rdata0 (rdata0),
    .rdata1 (rdata1),
    .result (result)
  );

endmodule

/* run_sim.sh */
#!/bin/sh
# build the core and its testbench with Verilator, run, then scan the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module rv_exec_tb \
  -f compile.f -o rv_exec_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/rv_exec_sim > sim.log 2>&1
cat sim.log
grep -q "Done: errors found" sim.log && exit 1
grep -q "Done: no errors" sim.log || exit 1
exit 0

/* verification/rv_exec_tb.sv */
//--------------------------------------------------------------------------
// testbench for the RV32 execution core
// table of ADD/ADDI/MUL rows checked against a reference register model
//--------------------------------------------------------------------------

`timescale 1ns/1ps

`include "core_cfg.svh"

module rv_exec_tb;

  import isa_pkg::*;
  import core_pkg::*;

  // negedges allowed per handshake wait
  localparam int TIMEOUT = 40;

  // one stimulus row with its expected response
  typedef struct packed {
    logic       cfg_en;
    logic [1:0] mask;
    rv_inst_t   word;
    issue_rsp_t exp;
  } tb_row_t;

  logic                  clk;
  logic                  reset;
  logic                  req;
  rv_inst_t              inst;
  logic                  ack;
  issue_rsp_t            rsp;
  cfg_req_t              cfg;
  logic [`CORE_XLEN-1:0] cfg_rdata;

  // stimulus table, names kept alongside
  string   row_name[$];
  tb_row_t rows[$];

  // reference model state
  logic [`CORE_XLEN-1:0] model_regs [`CORE_NREGS];
  logic [1:0]            model_mask;
  int unsigned           model_retired;
  int unsigned           model_illegal;

  rv_exec_top UUT (
    .clk       (clk),
    .reset     (reset),
    .req       (req),
    .inst      (inst),
    .ack       (ack),
    .rsp       (rsp),
    .cfg       (cfg),
    .cfg_rdata (cfg_rdata)
  );

  // 4 ns period
  always #2 clk = ~clk;

  //------------------------------------------------------------------------
  // checking
  //------------------------------------------------------------------------

  task automatic compare(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act) begin
      $display("MISMATCH %s: expected %0h, actual %0h", name, exp, act);
      $display("Done: errors found");
      $fatal(1, "simulation stopped");
    end
  endtask

  task automatic timed_out(input string what);
    $display("timeout while waiting for %s", what);
    $display("Done: errors found");
    $fatal(1, "simulation stopped");
  endtask

  //------------------------------------------------------------------------
  // instruction encoding
  //------------------------------------------------------------------------

  // R-type on the OP opcode, funct3 of ADD
  function automatic rv_inst_t enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                     input logic [4:0] rs1, input logic [4:0] rd);
    rv_inst_t w;
    w.r.funct7 = f7;
    w.r.rs2    = rs2;
    w.r.rs1    = rs1;
    w.r.funct3 = F3_ADD;
    w.r.rd     = rd;
    w.r.opcode = OPC_OP;
    return w;
  endfunction

  // ADDI
  function automatic rv_inst_t enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                     input logic [4:0] rd);
    rv_inst_t w;
    w.i.imm12  = imm;
    w.i.rs1    = rs1;
    w.i.funct3 = F3_ADD;
    w.i.rd     = rd;
    w.i.opcode = OPC_OP_IMM;
    return w;
  endfunction

  //------------------------------------------------------------------------
  // reference model, fills one table row
  //------------------------------------------------------------------------

  task automatic add_row(input string name, input logic cfg_en, input logic [1:0] mask,
                         input rv_inst_t word);
    tb_row_t               r;
    logic [`CORE_XLEN-1:0] a;
    logic [`CORE_XLEN-1:0] b;
    logic [`CORE_XLEN-1:0] res;
    logic                  ok;
    if (cfg_en) model_mask = mask;
    r        = '0;
    r.cfg_en = cfg_en;
    r.mask   = mask;
    r.word   = word;
    a        = model_regs[word.r.rs1];
    b        = model_regs[word.r.rs2];
    res      = '0;
    ok       = 1'b0;
    // bit 0 gates ADD/ADDI, bit 1 gates MUL
    if (word.r.opcode == OPC_OP && word.r.funct3 == F3_ADD) begin
      if (word.r.funct7 == F7_BASE && model_mask[0]) begin
        res = a + b;
        ok  = 1'b1;
      end else if (word.r.funct7 == F7_MULDIV && model_mask[1]) begin
        res = a * b;
        ok  = 1'b1;
      end
    end else if (word.i.opcode == OPC_OP_IMM && word.i.funct3 == F3_ADD && model_mask[0]) begin
      res = a + `CORE_XLEN'(signed'(word.i.imm12));
      ok  = 1'b1;
    end
    if (ok) begin
      r.exp.result = res;
      r.exp.wen    = 1'b1;
      r.exp.waddr  = word.r.rd;
      if (word.r.rd != 5'd0) model_regs[word.r.rd] = res;
      model_retired++;
    end else begin
      // illegal: no write, zero result
      r.exp.illegal = 1'b1;
      model_illegal++;
    end
    row_name.push_back(name);
    rows.push_back(r);
  endtask

  task automatic build_table();
    int          k;
    int          kind;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [11:0] imm;
    // immediates from x0, negative ones too
    add_row("addi pos", 1'b0, 2'b00, enc_i(12'd5, 5'd0, 5'd1));
    add_row("addi neg", 1'b0, 2'b00, enc_i(12'hffd, 5'd0, 5'd2));
    add_row("addi min", 1'b0, 2'b00, enc_i(12'h800, 5'd0, 5'd3));
    add_row("addi max", 1'b0, 2'b00, enc_i(12'h7ff, 5'd0, 5'd4));
    add_row("addi all ones", 1'b0, 2'b00, enc_i(12'hfff, 5'd0, 5'd14));
    for (k = 5; k < 9; k++) begin
      imm = 12'($urandom());
      add_row("addi rand", 1'b0, 2'b00, enc_i(imm, 5'd0, 5'(k)));
    end
    add_row("readback x2", 1'b0, 2'b00, enc_r(F7_BASE, 5'd0, 5'd2, 5'd9));
    // arithmetic and wrap
    add_row("add", 1'b0, 2'b00, enc_r(F7_BASE, 5'd2, 5'd1, 5'd10));
    add_row("mul neg", 1'b0, 2'b00, enc_r(F7_MULDIV, 5'd3, 5'd2, 5'd11));
    add_row("mul max", 1'b0, 2'b00, enc_r(F7_MULDIV, 5'd4, 5'd4, 5'd12));
    add_row("add wrap", 1'b0, 2'b00, enc_r(F7_BASE, 5'd14, 5'd14, 5'd15));
    add_row("mul wrap", 1'b0, 2'b00, enc_r(F7_MULDIV, 5'd12, 5'd12, 5'd16));
    add_row("write x0", 1'b0, 2'b00, enc_r(F7_BASE, 5'd1, 5'd1, 5'd0));
    add_row("read x0", 1'b0, 2'b00, enc_r(F7_BASE, 5'd0, 5'd0, 5'd13));
    for (k = 0; k < 10; k++) begin
      kind = $urandom_range(2, 0);
      rd   = 5'($urandom_range(31, 1));
      rs1  = 5'($urandom_range(16, 0));
      rs2  = 5'($urandom_range(16, 0));
      imm  = 12'($urandom());
      case (kind)
        0:       add_row("rand add", 1'b0, 2'b00, enc_r(F7_BASE, rs2, rs1, rd));
        1:       add_row("rand mul", 1'b0, 2'b00, enc_r(F7_MULDIV, rs2, rs1, rd));
        default: add_row("rand addi", 1'b0, 2'b00, enc_i(imm, rs1, rd));
      endcase
    end
    // MUL group switched off, then back on
    // x20 holds a known value that the disabled rows must leave alone
    add_row("preset x20", 1'b0, 2'b00, enc_i(12'h123, 5'd0, 5'd20));
    add_row("mul disabled", 1'b1, 2'b01, enc_r(F7_MULDIV, 5'd4, 5'd4, 5'd20));
    add_row("add while mul off", 1'b0, 2'b00, enc_r(F7_BASE, 5'd1, 5'd1, 5'd21));
    add_row("mul restored", 1'b1, 2'b11, enc_r(F7_MULDIV, 5'd4, 5'd4, 5'd23));
    add_row("add disabled", 1'b1, 2'b00, enc_r(F7_BASE, 5'd1, 5'd1, 5'd20));
    add_row("add restored", 1'b1, 2'b11, enc_i(12'd7, 5'd1, 5'd22));
    // unknown opcode, and OP with an unsupported funct3
    add_row("bad opcode", 1'b0, 2'b00, rv_inst_t'({25'h0123456, 7'b0001011}));
    add_row("bad funct3", 1'b0, 2'b00, rv_inst_t'(32'h002091b3));
    // every register read back through the datapath
    for (k = 1; k < `CORE_NREGS; k++) begin
      add_row("sweep", 1'b0, 2'b00, enc_r(F7_BASE, 5'd0, 5'(k), 5'(k)));
    end
  endtask

  //------------------------------------------------------------------------
  // port drivers
  //------------------------------------------------------------------------

  // write lands on the second edge
  task automatic cfg_write(input logic [1:0] addr, input logic [`CORE_XLEN-1:0] data);
    @(posedge clk);
    cfg.wr    <= 1'b1;
    cfg.addr  <= addr;
    cfg.wdata <= data;
    @(posedge clk);
    cfg.wr    <= 1'b0;
  endtask

  task automatic cfg_read(input logic [1:0] addr, output logic [`CORE_XLEN-1:0] data);
    @(posedge clk);
    cfg.addr <= addr;
    @(negedge clk);
    data = cfg_rdata;
  endtask

  // one full four-phase handshake for table row idx
  task automatic apply_row(input int idx);
    tb_row_t r;
    int      n;
    int      hold;
    r    = rows[idx];
    hold = idx % 3;
    if (r.cfg_en) cfg_write(CFG_ADDR_MASK, {{(`CORE_XLEN-2){1'b0}}, r.mask});
    @(posedge clk);
    req  <= 1'b1;
    inst <= r.word;
    // req sampled on the next edge, ack two edges later
    n = 0;
    @(negedge clk);
    n = 1;
    while (!ack) begin
      if (n >= TIMEOUT) timed_out({row_name[idx], " ack rise"});
      @(negedge clk);
      n++;
    end
    compare({row_name[idx], " ack latency"}, 64'(2), 64'(n - 2));
    compare({row_name[idx], " rsp"}, 64'(r.exp), 64'(rsp));
    // back-pressure
    repeat (hold) begin
      @(negedge clk);
      compare({row_name[idx], " ack held"}, 64'(1), 64'(ack));
    end
    @(posedge clk);
    req <= 1'b0;
    n = 0;
    @(negedge clk);
    while (ack) begin
      if (n >= TIMEOUT) timed_out({row_name[idx], " ack fall"});
      @(negedge clk);
      n++;
    end
  endtask

  //------------------------------------------------------------------------
  // main sequence
  //------------------------------------------------------------------------

  initial begin
    logic [`CORE_XLEN-1:0] rd_val;
    int                    i;
    clk   = 1'b0;
    reset = 1'b1;
    req   = 1'b0;
    inst  = '0;
    cfg   = '0;
    void'($urandom(8));
    for (i = 0; i < `CORE_NREGS; i++) model_regs[i] = '0;
    model_mask    = `CORE_OPEN_RESET;
    model_retired = 0;
    model_illegal = 0;
    build_table();
    repeat (5) @(posedge clk);
    reset <= 1'b0;
    for (i = 0; i < rows.size(); i++) begin
      apply_row(i);
    end
    // counters and mask against the model
    cfg_read(CFG_ADDR_RETIRED, rd_val);
    compare("retired count", 64'(model_retired), 64'(rd_val));
    cfg_read(CFG_ADDR_ILLEGAL, rd_val);
    compare("illegal count", 64'(model_illegal), 64'(rd_val));
    cfg_read(CFG_ADDR_MASK, rd_val);
    compare("enable mask", 64'(model_mask), 64'(rd_val));
    $display("Done: no errors");
    $finish;
  end

endmodule
